// ==== filelist.f ====
+incdir+verilog
verilog/div_pkg.sv
verilog/div_stream_ingress.sv
verilog/div_ctrl.sv
verilog/div_shift_sub.sv
verilog/div_result_reg.sv
verilog/div_stream_top.sv
tests/tb_clkgen.sv
tests/div_stream_checker.sv
tests/div_stream_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the divider testbench with Verilator.
# A failing check ends the run through $fatal, so the exit status carries the result.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module div_stream_tb \
  -f filelist.f \
  -o div_stream_sim

./obj_dir/div_stream_sim

// ==== tests/div_stream_checker.sv ====
/* Protocol assertions of the stream divider, bound into the top level.
   Only one operation may be in flight, results are single-cycle strobes. */

`timescale 1ns/1ps

module div_stream_checker (
  input logic              clk,
  input logic              rst_n,
  input logic              in_valid,
  input logic              in_ready,
  input logic              start,
  input logic              out_valid,
  input div_pkg::operand_t out_data,
  input logic              out_overflow
);

  logic busy;  // Between start and the result strobe

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
    end else if (start) begin
      busy <= 1'b1;
    end else if (out_valid) begin
      busy <= 1'b0;  // Result handed out
    end
  end

  ////////////////////
  // Strobe rules
  ////////////////////

  a_strobe_single: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |=> !out_valid)
    else $error("out_valid stayed high for two cycles");

  // Idle outputs right after reset release
  a_reset_state: assert property (@(posedge clk)
    $rose(rst_n) |-> (!out_valid && in_ready))
    else $error("out_valid or in_ready wrong after reset");

  a_ovf_saturates: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && out_overflow) |-> (out_data == '1))
    else $error("overflow result is not all ones");

  ////////////////////
  // Ingress while busy
  ////////////////////

  a_no_beat_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (start || (busy && !out_valid)) |-> !(in_valid && in_ready))
    else $error("beat accepted while an operation was running");

endmodule

bind div_stream_top div_stream_checker div_stream_checker_inst (
  .clk          ( clk          ),
  .rst_n        ( rst_n        ),
  .in_valid     ( in_valid     ),
  .in_ready     ( in_ready     ),
  .start        ( start        ),
  .out_valid    ( out_valid    ),
  .out_data     ( out_data     ),
  .out_overflow ( out_overflow )
);

// ==== tests/div_stream_tb.sv ====
/* Testbench of the stream divider. Fixed table first, then seeded random ops.
   Inputs change on the falling edge and outputs are sampled there too.
   A table entry marked b2b has its dividend held on the bus while the DUT is busy. */

`timescale 1ns/1ps

`include "div_params.svh"

module div_stream_tb;

  import div_pkg::*;

  localparam int N            = `DIV_N_BITS;
  localparam int Q            = `DIV_Q_BITS;
  localparam int LATENCY      = N + Q + 2;  // Edges from divisor accept to strobe
  localparam int NUM_TBL      = 12;
  localparam int NUM_RAND     = 40;
  localparam int PERIOD_NS    = 40;
  localparam int RESET_CYCLES = 8;
  localparam int WATCHDOG_NS  = (NUM_TBL + NUM_RAND) * (N + Q + 10) * PERIOD_NS
                                + RESET_CYCLES * PERIOD_NS;

  typedef struct packed {
    operand_t   dividend;
    operand_t   divisor;
    stream_id_t id;
    operand_t   exp_q;
    logic       exp_ovf;
    logic       b2b;      // Dividend presented while previous op runs
  } op_t;

  logic       clk;
  logic       rst_n;
  logic       in_valid;
  logic       in_ready;
  operand_t   in_data;
  logic       in_last;
  stream_id_t in_id;
  logic       out_valid;
  operand_t   out_data;
  stream_id_t out_id;
  logic       out_overflow;

  op_t  ops[$];         // Table, then random ops
  logic div_pending;    // Next dividend already accepted
  int   seed = 66533;

  tb_clkgen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) tb_clkgen_inst (
    .clk   ( clk   ),
    .rst_n ( rst_n )
  );

  div_stream_top div_stream_top_inst (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .in_valid     ( in_valid     ),
    .in_ready     ( in_ready     ),
    .in_data      ( in_data      ),
    .in_last      ( in_last      ),
    .in_id        ( in_id        ),
    .out_valid    ( out_valid    ),
    .out_data     ( out_data     ),
    .out_id       ( out_id       ),
    .out_overflow ( out_overflow )
  );

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic stop_with_failure(input string why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "%s", why);
  endtask

  task automatic check_quotient(input operand_t got, input operand_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: quotient is %h, expected %h", $time, got, exp);
      stop_with_failure("quotient mismatch");
    end
  endtask

  task automatic check_id(input stream_id_t got, input stream_id_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: out_id is %h, expected %h", $time, got, exp);
      stop_with_failure("id mismatch");
    end
  endtask

  task automatic check_overflow(input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: out_overflow is %b, expected %b", $time, got, exp);
      stop_with_failure("overflow mismatch");
    end
  endtask

  // Handshake levels, in_ready and out_valid
  task automatic check_level(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
      stop_with_failure("handshake level mismatch");
    end
  endtask

  task automatic check_latency(input int got, input int exp);
    if (got != exp) begin
      $display("[ERROR] %0t: latency is %0d edges, expected %0d", $time, got, exp);
      stop_with_failure("latency mismatch");
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  // floor(a * 2^Q / b), saturated when b is zero or the result needs more than N bits
  function automatic void ref_div(input operand_t a, input operand_t b,
                                  output operand_t q, output logic ovf);
    longint unsigned wide;
    if (b == '0) begin
      ovf = 1'b1;
      q   = '1;
    end else begin
      wide = (64'(a) << Q) / 64'(b);
      ovf  = (wide >= (64'd1 << N));
      q    = ovf ? '1 : wide[N-1:0];
    end
  endfunction

  function automatic op_t make_op(input operand_t a, input operand_t b, input stream_id_t id,
                                  input operand_t exp_q, input logic exp_ovf, input logic b2b);
    op_t op;
    op.dividend = a;
    op.divisor  = b;
    op.id       = id;
    op.exp_q    = exp_q;
    op.exp_ovf  = exp_ovf;
    op.b2b      = b2b;
    return op;
  endfunction

  task automatic build_ops();
    logic [31:0] rnd;
    operand_t    a;
    operand_t    b;
    operand_t    q;
    logic        ovf;
    // Hand-worked table with Q = 8 fraction bits
    ops.push_back(make_op(16'h0003, 16'h0002, 4'h1, 16'h0180, 1'b0, 1'b0));
    ops.push_back(make_op(16'h0001, 16'h0003, 4'h2, 16'h0055, 1'b0, 1'b1));
    ops.push_back(make_op(16'h0005, 16'h0000, 4'h3, 16'hffff, 1'b1, 1'b0)); // Divide by zero
    ops.push_back(make_op(16'h8000, 16'h0001, 4'h4, 16'hffff, 1'b1, 1'b1)); // Too large
    ops.push_back(make_op(16'h0000, 16'h0007, 4'h5, 16'h0000, 1'b0, 1'b0));
    ops.push_back(make_op(16'hffff, 16'hffff, 4'h6, 16'h0100, 1'b0, 1'b1));
    ops.push_back(make_op(16'h0001, 16'h0100, 4'h7, 16'h0001, 1'b0, 1'b0));
    ops.push_back(make_op(16'h00ff, 16'h0001, 4'h8, 16'hff00, 1'b0, 1'b1));
    ops.push_back(make_op(16'h0100, 16'h0001, 4'h9, 16'hffff, 1'b1, 1'b1)); // Exactly 2^N
    ops.push_back(make_op(16'h0064, 16'h0007, 4'ha, 16'h0e49, 1'b0, 1'b0));
    ops.push_back(make_op(16'h1234, 16'h0056, 4'hb, 16'h362f, 1'b0, 1'b1));
    ops.push_back(make_op(16'hffff, 16'h0100, 4'hc, 16'hffff, 1'b0, 1'b0)); // Fits, no ovf
    for (int i = 0; i < NUM_RAND; i++) begin
      rnd = $random(seed);
      a   = operand_t'(rnd);
      rnd = $random(seed);
      b   = operand_t'(rnd);
      rnd = $random(seed);
      if (rnd[2:0] == 3'd0) begin
        b = b >> (N / 2);  // Small divisor, overflow likely
      end
      if (rnd[7:3] == 5'd0) begin
        b = '0;
      end
      ref_div(a, b, q, ovf);
      ops.push_back(make_op(a, b, stream_id_t'(rnd >> 8), q, ovf, rnd[16]));
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  // Returns at the rising edge that accepts the beat
  task automatic send_beat(input operand_t data, input logic last, input stream_id_t id);
    @(negedge clk);
    in_valid <= 1'b1;
    in_data  <= data;
    in_last  <= last;
    in_id    <= id;
    while (!in_ready) @(negedge clk);  // Held under back-pressure
    @(posedge clk);
  endtask

  task automatic run_op(input int idx);
    op_t  cur;
    logic chain;
    int   lat;
    cur   = ops[idx];
    chain = (idx + 1 < ops.size()) && ops[idx + 1].b2b;
    if (!div_pending) begin
      send_beat(cur.dividend, 1'b0, cur.id);
    end
    send_beat(cur.divisor, 1'b1, cur.id);
    lat = 0;
    @(negedge clk);
    if (chain) begin
      in_valid <= 1'b1;  // Next dividend waits for ready
      in_data  <= ops[idx + 1].dividend;
      in_last  <= 1'b0;
      in_id    <= ops[idx + 1].id;
    end else begin
      in_valid <= 1'b0;
    end
    while (!out_valid) begin
      check_level("in_ready while busy", in_ready, 1'b0);
      @(negedge clk);
      lat++;
    end
    check_latency(lat, LATENCY);
    check_quotient(out_data, cur.exp_q);
    check_overflow(out_overflow, cur.exp_ovf);
    check_id(out_id, cur.id);
    check_level("in_ready with result", in_ready, 1'b1);
    @(negedge clk);  // Held dividend taken on the edge before
    in_valid <= 1'b0;
    check_level("out_valid one cycle later", out_valid, 1'b0);
    div_pending = chain;
  endtask

  initial begin
    in_valid    = 1'b0;
    in_data     = '0;
    in_last     = 1'b0;
    in_id       = '0;
    div_pending = 1'b0;
    build_ops();
    @(posedge rst_n);
    @(negedge clk);
    check_level("in_ready after reset", in_ready, 1'b1);
    check_level("out_valid after reset", out_valid, 1'b0);
    for (int i = 0; i < ops.size(); i++) begin
      run_op(i);
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

  // Bounded by op count and per-op latency
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired, no result arrived from the DUT in time");
    stop_with_failure("watchdog timeout");
  end

endmodule

// ==== tests/tb_clkgen.sv ====
/* Testbench clock and reset. Reset is released on a falling edge,
   away from the sampling edge of the DUT. */

`timescale 1ns/1ps

module tb_clkgen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;  // Free running
  end

  initial begin
    rst_n = 1'b0;  // Asserted from time zero
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// ==== verilog/div_ctrl.sv ====
/* Control FSM of the iterative divider. One operation in flight.
   IDLE -> ITER on start, N+Q steps in ITER, one DONE cycle, back to IDLE.
   Ready is dropped as soon as start is seen and returns with the result strobe. */

`timescale 1ns/1ps

`include "div_params.svh"

module div_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic start,      // From ingress
  output logic accept_en,  // Becomes in_ready
  output logic step,       // Datapath advances one bit
  output logic done        // Result valid at datapath outputs
);

  import div_pkg::*;

  localparam int unsigned STEPS = `DIV_N_BITS + `DIV_Q_BITS;
  localparam step_cnt_t   LAST_STEP = step_cnt_t'(STEPS - 1);

  div_state_t state;
  div_state_t state_nxt;
  step_cnt_t  step_cnt;  // Steps done so far in ITER

  ////////////////////
  // State register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      step_cnt <= '0;
    end else begin
      state <= state_nxt;
      if (state == ITER) begin
        step_cnt <= step_cnt + 1'b1;
      end else begin
        step_cnt <= '0;  // Ready for next run
      end
    end
  end

  ////////////////////
  // Next state
  ////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (start) begin
          state_nxt = ITER;  // Datapath loads on same edge
        end
      end
      ITER: begin
        // Last step happens on this edge
        if (step_cnt == LAST_STEP) begin
          state_nxt = DONE;
        end
      end
      DONE: begin
        state_nxt = IDLE;
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  // Outputs decoded from state
  assign accept_en = (state == IDLE) && !start;  // Low from the start cycle on
  assign step      = (state == ITER);
  assign done      = (state == DONE);

endmodule

// ==== verilog/div_params.svh ====
/* Default sizing of the fixed-point divider.
   Q_BITS must stay below N_BITS. The iteration count is N+Q steps per operation. */

`ifndef DIV_PARAMS_SVH
`define DIV_PARAMS_SVH

////////////////////
// Core sizing
////////////////////

// Operand and quotient width
`define DIV_N_BITS 16

// Fraction bits of the quotient
`define DIV_Q_BITS 8

// Stream id width
`define DIV_ID_BITS 4

`endif

// ==== verilog/div_pkg.sv ====
/* Shared types of the divider. Widths follow div_params.svh.
   Quotient is unsigned, Q fraction bits, saturating on overflow. */

package div_pkg;

  `include "div_params.svh"

  ////////////////////
  // Data types
  ////////////////////

  typedef logic [`DIV_N_BITS-1:0]              operand_t;   // Dividend, divisor, quotient
  typedef logic [`DIV_ID_BITS-1:0]             stream_id_t; // Ingress/egress id
  typedef logic [`DIV_N_BITS+`DIV_Q_BITS-1:0]  wide_quot_t; // Raw quotient, N+Q bits

  // Iteration counter, must reach N+Q
  typedef logic [$clog2(`DIV_N_BITS+`DIV_Q_BITS+1)-1:0] step_cnt_t;

  ////////////////////
  // Control FSM
  ////////////////////

  typedef enum logic [1:0] {
    IDLE = 2'd0,  // Waiting for an operation
    ITER = 2'd1,  // One quotient bit per clock
    DONE = 2'd2   // Result handed to egress
  } div_state_t;

endpackage

// ==== verilog/div_result_reg.sv ====
/* Egress register. Result is a one-cycle strobe, no back-pressure.
   out_data, out_id and out_overflow hold between strobes. */

`timescale 1ns/1ps

module div_result_reg (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,     // Operation begins
  input  div_pkg::stream_id_t op_id,
  input  logic                done,      // Datapath result valid
  input  div_pkg::operand_t   quotient,
  input  logic                overflow,
  output logic                out_valid,
  output div_pkg::operand_t   out_data,
  output div_pkg::stream_id_t out_id,
  output logic                out_overflow
);

  import div_pkg::*;

  stream_id_t id_hold;  // Safe from a new dividend beat

  // Id of the running operation
  always_ff @(posedge clk) begin
    if (start) begin
      id_hold <= op_id;
    end
  end

  ////////////////////
  // Result strobe
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= done;  // Exactly one cycle
    end
  end

  // Payload, captured with the strobe
  always_ff @(posedge clk) begin
    if (done) begin
      out_data     <= quotient;
      out_overflow <= overflow;
      out_id       <= id_hold;
    end
  end

endmodule

// ==== verilog/div_shift_sub.sv ====
/* Restoring shift-subtract datapath, unsigned only, no rounding.
   Computes floor(dividend * 2^Q / divisor) over N+Q steps.
   Outputs are valid once the last step has completed. Zero divisor or a
   quotient of 2^N or more flags overflow and saturates to all ones. */

`timescale 1ns/1ps

`include "div_params.svh"

module div_shift_sub (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,     // Load operands
  input  logic              step,      // One quotient bit
  input  div_pkg::operand_t dividend,
  input  div_pkg::operand_t divisor,
  output div_pkg::operand_t quotient,
  output logic              overflow
);

  import div_pkg::*;

  localparam int N = `DIV_N_BITS;
  localparam int Q = `DIV_Q_BITS;

  wide_quot_t quot_sr;    // Dividend bits out at top, quotient bits in at bottom
  logic [N:0] rem;        // Partial remainder, one extra bit
  operand_t   divisor_q;  // Latched divisor

  logic [N:0] rem_shift;  // Remainder with next dividend bit
  logic       q_bit;      // Subtract succeeds

  ////////////////////
  // Step logic
  ////////////////////

  assign rem_shift = {rem[N-1:0], quot_sr[N+Q-1]};
  assign q_bit     = (rem_shift >= {1'b0, divisor_q});

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      quot_sr   <= '0;
      rem       <= '0;
      divisor_q <= '0;
    end else if (start) begin
      // Dividend scaled by 2^Q
      quot_sr   <= {dividend, {Q{1'b0}}};
      rem       <= '0;
      divisor_q <= divisor;
    end else if (step) begin
      if (q_bit) begin
        rem <= rem_shift - {1'b0, divisor_q};  // Restore not needed
      end else begin
        rem <= rem_shift;
      end
      quot_sr <= {quot_sr[N+Q-2:0], q_bit};
    end
  end

  ////////////////////
  // Result
  ////////////////////

  // Any of the top Q bits means the quotient does not fit in N
  assign overflow = (divisor_q == '0) || (|quot_sr[N+Q-1:N]);
  assign quotient = overflow ? '1 : quot_sr[N-1:0];  // Saturate

endmodule

// ==== verilog/div_stream_ingress.sv ====
/* Two-beat ingress. Dividend beat has last low, divisor beat has last high.
   A divisor without a fresh dividend reuses the dividend held last.
   The id of the latest accepted beat is kept on op_id. */

`timescale 1ns/1ps

module div_stream_ingress (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  output logic                in_ready,
  input  div_pkg::operand_t   in_data,
  input  logic                in_last,
  input  div_pkg::stream_id_t in_id,
  input  logic                accept_en,  // From control FSM
  output logic                start,      // One cycle after divisor beat
  output div_pkg::operand_t   dividend,
  output div_pkg::operand_t   divisor,
  output div_pkg::stream_id_t op_id
);

  import div_pkg::*;

  operand_t   dividend_q;  // Held operands
  operand_t   divisor_q;
  stream_id_t id_q;
  logic       beat_acc;    // Handshake on this edge

  // Ready comes straight from the FSM
  assign in_ready = accept_en;
  assign beat_acc = in_valid && accept_en;

  ////////////////////
  // Start pulse
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start <= 1'b0;
    end else begin
      start <= beat_acc && in_last;  // Divisor beat only
    end
  end

  ////////////////////
  // Operand capture
  ////////////////////

  // Steer by last into dividend or divisor
  always_ff @(posedge clk) begin
    if (beat_acc) begin
      id_q <= in_id;
      if (!in_last) begin
        dividend_q <= in_data;
      end else begin
        divisor_q <= in_data;
      end
    end
  end

  assign dividend = dividend_q;
  assign divisor  = divisor_q;
  assign op_id    = id_q;  // Result reg samples this at start

endmodule

// ==== verilog/div_stream_top.sv ====
/* Stream divider top. Ingress takes dividend then divisor, egress is a strobe.
   Fixed latency of N+Q+2 edges from divisor accept to out_valid. */

`timescale 1ns/1ps

module div_stream_top (
  input  logic                clk,
  input  logic                rst_n,
  // Ingress stream
  input  logic                in_valid,
  output logic                in_ready,
  input  div_pkg::operand_t   in_data,
  input  logic                in_last,   // High on divisor beat
  input  div_pkg::stream_id_t in_id,
  // Egress strobe
  output logic                out_valid,
  output div_pkg::operand_t   out_data,  // Quotient
  output div_pkg::stream_id_t out_id,
  output logic                out_overflow
);

  logic                start;
  logic                accept_en;
  logic                step;
  logic                done;
  logic                overflow;
  div_pkg::operand_t   dividend;
  div_pkg::operand_t   divisor;
  div_pkg::operand_t   quotient;
  div_pkg::stream_id_t op_id;

  ////////////////////
  // Blocks
  ////////////////////

  div_stream_ingress div_stream_ingress_inst (
    .clk       ( clk       ),
    .rst_n     ( rst_n     ),
    .in_valid  ( in_valid  ),
    .in_ready  ( in_ready  ),
    .in_data   ( in_data   ),
    .in_last   ( in_last   ),
    .in_id     ( in_id     ),
    .accept_en ( accept_en ),
    .start     ( start     ),
    .dividend  ( dividend  ),
    .divisor   ( divisor   ),
    .op_id     ( op_id     )
  );

  div_ctrl div_ctrl_inst (
    .clk       ( clk       ),
    .rst_n     ( rst_n     ),
    .start     ( start     ),
    .accept_en ( accept_en ),
    .step      ( step      ),
    .done      ( done      )
  );

  div_shift_sub div_shift_sub_inst (
    .clk      ( clk      ),
    .rst_n    ( rst_n    ),
    .start    ( start    ),
    .step     ( step     ),
    .dividend ( dividend ),
    .divisor  ( divisor  ),
    .quotient ( quotient ),
    .overflow ( overflow )
  );

  div_result_reg div_result_reg_inst (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .start        ( start        ),
    .op_id        ( op_id        ),
    .done         ( done         ),
    .quotient     ( quotient     ),
    .overflow     ( overflow     ),
    .out_valid    ( out_valid    ),
    .out_data     ( out_data     ),
    .out_id       ( out_id       ),
    .out_overflow ( out_overflow )
  );

endmodule
